/* hdl/rename_pkg.sv */
////////////////////
// rename core shared definitions
// sizes, tag and register types
// packets between dispatch, rob, map table and rs
////////////////////

package rename_pkg;

    localparam int reg_size    = 32;
    localparam int rob_size    = 32;
    localparam int rob_idx_len = 5;

    typedef logic [$clog2(reg_size)-1:0] arch_reg_t;
    typedef logic [rob_idx_len-1:0]      rob_idx_t;
    // top bit set means the value sits in the register file
    typedef logic [rob_idx_len:0]        rob_tag_t;
    // rob occupancy, 0 up to rob_size
    typedef logic [rob_idx_len:0]        rob_cnt_t;

    localparam rob_tag_t zero_tag = {1'b1, {rob_idx_len{1'b0}}};

    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t dest_reg;
    } dispatch_slot_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } cdb_entry_t;

    // rob to map table, one per slot
    typedef struct packed {
        logic      dispatch_fire;
        rob_tag_t  rob_tail;
        logic      dispatch_dest_valid;
        arch_reg_t dispatch_dest_reg;
        logic      dest_valid;
        arch_reg_t dest_reg_idx;
        rob_tag_t  rob_head;
        logic      squash;
    } rob_mt_packet_t;

    typedef struct packed {
        arch_reg_t [1:0] register_idxes;
    } rs_mt_packet_t;

    typedef struct packed {
        rob_tag_t tag;
        logic     ready;
    } operand_info_t;

    typedef struct packed {
        operand_info_t [1:0] rs_infos;
    } mt_rs_packet_t;

    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t dest_reg;
        rob_tag_t  tag;
    } retire_packet_t;

endpackage

/* hdl/map_table.sv */
////////////////////
// map table
// arch register to rob tag, with ready bits
// lookups with retire and same-cycle dispatch overrides
////////////////////

`timescale 1ns/100ps

module map_table (
    input  logic                       clock,
    input  logic                       reset,

    input  rename_pkg::rob_mt_packet_t rob_mt_0,
    input  rename_pkg::rob_mt_packet_t rob_mt_1,

    input  rename_pkg::cdb_entry_t     cdb_0,
    input  rename_pkg::cdb_entry_t     cdb_1,

    input  rename_pkg::rs_mt_packet_t  lookup_0,
    input  rename_pkg::rs_mt_packet_t  lookup_1,

    output rename_pkg::mt_rs_packet_t  operands_0,
    output rename_pkg::mt_rs_packet_t  operands_1
);
    import rename_pkg::*;

    // table state
    rob_tag_t            tag_table [reg_size];
    logic [reg_size-1:0] ready_table;

    rob_tag_t            tag_next [reg_size];
    logic [reg_size-1:0] ready_next;

    logic clear_0;
    logic clear_1;
    logic rename_0;
    logic rename_1;

    // only clear when the entry still points at the retiring tag
    assign clear_0 = rob_mt_0.dest_valid && tag_table[rob_mt_0.dest_reg_idx] == rob_mt_0.rob_head;
    assign clear_1 = rob_mt_1.dest_valid && tag_table[rob_mt_1.dest_reg_idx] == rob_mt_1.rob_head;

    assign rename_0 = rob_mt_0.dispatch_fire && rob_mt_0.dispatch_dest_valid;
    assign rename_1 = rob_mt_1.dispatch_fire && rob_mt_1.dispatch_dest_valid;

    ////////////////////
    // lookups
    ////////////////////

    function automatic operand_info_t read_operand(input arch_reg_t idx, input logic fwd);
        operand_info_t info;
        info.tag   = tag_table[idx];
        info.ready = ready_table[idx];
        // retiring this cycle, value already in the register file
        if ((clear_0 && rob_mt_0.dest_reg_idx == idx) ||
            (clear_1 && rob_mt_1.dest_reg_idx == idx)) begin
            info.tag   = zero_tag;
            info.ready = 1'b0;
        end
        // slot 1 depends on slot 0 of the same bundle
        if (fwd && rename_0 && rob_mt_0.dispatch_dest_reg == idx) begin
            info.tag   = rob_mt_0.rob_tail;
            info.ready = 1'b0;
        end
        return info;
    endfunction

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            operands_0.rs_infos[s] = read_operand(lookup_0.register_idxes[s], 1'b0);
            operands_1.rs_infos[s] = read_operand(lookup_1.register_idxes[s], 1'b1);
        end
    end

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        tag_next   = tag_table;
        ready_next = ready_table;

        // retire first
        if (clear_0) begin
            tag_next[rob_mt_0.dest_reg_idx]   = zero_tag;
            ready_next[rob_mt_0.dest_reg_idx] = 1'b0;
        end
        if (clear_1) begin
            tag_next[rob_mt_1.dest_reg_idx]   = zero_tag;
            ready_next[rob_mt_1.dest_reg_idx] = 1'b0;
        end

        // completion broadcast
        for (int i = 0; i < reg_size; i++) begin
            if ((cdb_0.valid && tag_table[i] == cdb_0.tag) ||
                (cdb_1.valid && tag_table[i] == cdb_1.tag)) begin
                ready_next[i] = 1'b1;
            end
        end

        // dispatch last, slot 1 wins on the same register
        if (rename_0) begin
            tag_next[rob_mt_0.dispatch_dest_reg]   = rob_mt_0.rob_tail;
            ready_next[rob_mt_0.dispatch_dest_reg] = 1'b0;
        end
        if (rename_1) begin
            tag_next[rob_mt_1.dispatch_dest_reg]   = rob_mt_1.rob_tail;
            ready_next[rob_mt_1.dispatch_dest_reg] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || rob_mt_0.squash || rob_mt_1.squash) begin
            // everything back to the register file
            for (int i = 0; i < reg_size; i++) begin
                tag_table[i] <= zero_tag;
            end
            ready_table <= '0;
        end else begin
            tag_table   <= tag_next;
            ready_table <= ready_next;
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
////////////////////
// reorder buffer
// tag allocation, completion, in-order retire
////////////////////

`timescale 1ns/100ps

module reorder_buffer (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,

    input  rename_pkg::dispatch_slot_t dispatch_0,
    input  rename_pkg::dispatch_slot_t dispatch_1,

    input  rename_pkg::cdb_entry_t     cdb_0,
    input  rename_pkg::cdb_entry_t     cdb_1,

    output logic                       dispatch_ready,
    output rename_pkg::rob_mt_packet_t rob_mt_0,
    output rename_pkg::rob_mt_packet_t rob_mt_1,
    output rename_pkg::retire_packet_t retire_0,
    output rename_pkg::retire_packet_t retire_1
);
    import rename_pkg::*;

    // control state
    logic [rob_size-1:0] entry_valid;
    logic [rob_size-1:0] entry_complete;
    rob_idx_t            head;
    rob_idx_t            tail;
    rob_cnt_t            count;

    // payload
    logic [rob_size-1:0] entry_has_dest;
    arch_reg_t           entry_dest_reg [rob_size];

    logic [rob_size-1:0] valid_next;
    logic [rob_size-1:0] complete_next;

    logic     fire_0;
    logic     fire_1;
    logic     retire_fire_0;
    logic     retire_fire_1;
    rob_idx_t head_1;
    rob_idx_t tail_1;
    rob_cnt_t fire_cnt;
    rob_cnt_t retire_cnt;

    // two free entries so a full bundle always fits
    assign dispatch_ready = count <= rob_cnt_t'(rob_size - 2);

    assign fire_0 = dispatch_0.valid && dispatch_ready;
    assign fire_1 = dispatch_1.valid && dispatch_ready;
    assign tail_1 = tail + rob_idx_t'(fire_0);
    assign head_1 = head + rob_idx_t'(1);

    assign retire_fire_0 = entry_valid[head] && entry_complete[head];
    assign retire_fire_1 = retire_fire_0 && entry_valid[head_1] && entry_complete[head_1];

    assign fire_cnt   = rob_cnt_t'(fire_0) + rob_cnt_t'(fire_1);
    assign retire_cnt = rob_cnt_t'(retire_fire_0) + rob_cnt_t'(retire_fire_1);

    ////////////////////
    // outputs
    ////////////////////

    always_comb begin
        retire_0.valid    = retire_fire_0;
        retire_0.has_dest = entry_has_dest[head];
        retire_0.dest_reg = entry_dest_reg[head];
        retire_0.tag      = {1'b0, head};
        retire_1.valid    = retire_fire_1;
        retire_1.has_dest = entry_has_dest[head_1];
        retire_1.dest_reg = entry_dest_reg[head_1];
        retire_1.tag      = {1'b0, head_1};
    end

    always_comb begin
        rob_mt_0.dispatch_fire       = fire_0;
        rob_mt_0.rob_tail            = {1'b0, tail};
        rob_mt_0.dispatch_dest_valid = dispatch_0.has_dest;
        rob_mt_0.dispatch_dest_reg   = dispatch_0.dest_reg;
        rob_mt_0.dest_valid          = retire_0.valid && retire_0.has_dest;
        rob_mt_0.dest_reg_idx        = retire_0.dest_reg;
        rob_mt_0.rob_head            = retire_0.tag;
        rob_mt_0.squash              = squash;

        rob_mt_1.dispatch_fire       = fire_1;
        rob_mt_1.rob_tail            = {1'b0, tail_1};
        rob_mt_1.dispatch_dest_valid = dispatch_1.has_dest;
        rob_mt_1.dispatch_dest_reg   = dispatch_1.dest_reg;
        rob_mt_1.dest_valid          = retire_1.valid && retire_1.has_dest;
        rob_mt_1.dest_reg_idx        = retire_1.dest_reg;
        rob_mt_1.rob_head            = retire_1.tag;
        rob_mt_1.squash              = squash;
    end

    ////////////////////
    // entry state
    ////////////////////

    always_comb begin
        valid_next    = entry_valid;
        complete_next = entry_complete;
        if (retire_fire_0) begin
            valid_next[head] = 1'b0;
        end
        if (retire_fire_1) begin
            valid_next[head_1] = 1'b0;
        end
        // cdb tags never carry the zero_tag bit
        if (cdb_0.valid && !cdb_0.tag[rob_idx_len]) begin
            complete_next[rob_idx_t'(cdb_0.tag)] = 1'b1;
        end
        if (cdb_1.valid && !cdb_1.tag[rob_idx_len]) begin
            complete_next[rob_idx_t'(cdb_1.tag)] = 1'b1;
        end
        if (fire_0) begin
            valid_next[tail]    = 1'b1;
            complete_next[tail] = 1'b0;
        end
        if (fire_1) begin
            valid_next[tail_1]    = 1'b1;
            complete_next[tail_1] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            entry_valid    <= '0;
            entry_complete <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
        end else begin
            entry_valid    <= valid_next;
            entry_complete <= complete_next;
            head           <= head + rob_idx_t'(retire_cnt);
            tail           <= tail + rob_idx_t'(fire_cnt);
            count          <= count + fire_cnt - retire_cnt;
        end
    end

    always_ff @(posedge clock) begin
        if (fire_0) begin
            entry_has_dest[tail] <= dispatch_0.has_dest;
            entry_dest_reg[tail] <= dispatch_0.dest_reg;
        end
        if (fire_1) begin
            entry_has_dest[tail_1] <= dispatch_1.has_dest;
            entry_dest_reg[tail_1] <= dispatch_1.dest_reg;
        end
    end

endmodule

/* hdl/rename_core.sv */
////////////////////
// rename core top
// reorder buffer feeding the map table
////////////////////

`timescale 1ns/100ps

module rename_core (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,

    input  rename_pkg::dispatch_slot_t dispatch_0,
    input  rename_pkg::dispatch_slot_t dispatch_1,
    input  rename_pkg::cdb_entry_t     cdb_0,
    input  rename_pkg::cdb_entry_t     cdb_1,
    input  rename_pkg::rs_mt_packet_t  lookup_0,
    input  rename_pkg::rs_mt_packet_t  lookup_1,

    output logic                       dispatch_ready,
    output rename_pkg::mt_rs_packet_t  operands_0,
    output rename_pkg::mt_rs_packet_t  operands_1,
    output rename_pkg::retire_packet_t retire_0,
    output rename_pkg::retire_packet_t retire_1
);
    import rename_pkg::*;

    // dispatch, retire and squash info per slot
    rob_mt_packet_t rob_mt_0;
    rob_mt_packet_t rob_mt_1;

    reorder_buffer reorder_buffer_inst (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_0     (dispatch_0),
        .dispatch_1     (dispatch_1),
        .cdb_0          (cdb_0),
        .cdb_1          (cdb_1),
        .dispatch_ready (dispatch_ready),
        .rob_mt_0       (rob_mt_0),
        .rob_mt_1       (rob_mt_1),
        .retire_0       (retire_0),
        .retire_1       (retire_1)
    );

    map_table map_table_inst (
        .clock      (clock),
        .reset      (reset),
        .rob_mt_0   (rob_mt_0),
        .rob_mt_1   (rob_mt_1),
        .cdb_0      (cdb_0),
        .cdb_1      (cdb_1),
        .lookup_0   (lookup_0),
        .lookup_1   (lookup_1),
        .operands_0 (operands_0),
        .operands_1 (operands_1)
    );

endmodule

/* verification/rename_core_props.sv */
////////////////////
// reorder buffer assertions
////////////////////

`timescale 1ns/100ps

module rename_core_props (
    input logic                            clock,
    input logic                            reset,
    input logic                            squash,
    input logic                            dispatch_ready,
    input rename_pkg::rob_idx_t            tail,
    input rename_pkg::rob_cnt_t            count,
    input logic [rename_pkg::rob_size-1:0] entry_valid,
    input rename_pkg::rob_mt_packet_t      rob_mt_0,
    input rename_pkg::rob_mt_packet_t      rob_mt_1,
    input rename_pkg::retire_packet_t      retire_0,
    input rename_pkg::retire_packet_t      retire_1
);
    import rename_pkg::*;

    // second retire slot needs the first and two live entries
    retire_order: assert property (@(posedge clock) disable iff (reset)
        retire_1.valid |-> retire_0.valid && count >= rob_cnt_t'(2))
        else $error("retire_1 valid without two entries in flight");

    // a held-off bundle leaves the tail where it was
    no_fire_when_full: assert property (@(posedge clock) disable iff (reset)
        !dispatch_ready && !squash |=> tail == $past(tail))
        else $error("tail moved while dispatch_ready low");

    // tag handed to a firing slot names a free entry
    tail_entry_free: assert property (@(posedge clock) disable iff (reset)
        (!rob_mt_0.dispatch_fire || !entry_valid[rob_mt_0.rob_tail[rob_idx_len-1:0]]) &&
        (!rob_mt_1.dispatch_fire || !entry_valid[rob_mt_1.rob_tail[rob_idx_len-1:0]]))
        else $error("firing slot was given an entry still in flight");

endmodule

bind reorder_buffer rename_core_props rename_core_props_inst (
    .clock          (clock),
    .reset          (reset),
    .squash         (squash),
    .dispatch_ready (dispatch_ready),
    .tail           (tail),
    .count          (count),
    .entry_valid    (entry_valid),
    .rob_mt_0       (rob_mt_0),
    .rob_mt_1       (rob_mt_1),
    .retire_0       (retire_0),
    .retire_1       (retire_1)
);

/* verification/rename_core_tb.sv */
////////////////////
// rename core testbench
// reference model, lfsr, compare tasks
// directed tests and watchdog
////////////////////

`timescale 1ns/100ps

module rename_core_tb;
    import rename_pkg::*;

    localparam int cycle_budget = 16 + 4 + 12 + 4 * 200 + 60;
    localparam dispatch_slot_t no_disp = '0;
    localparam cdb_entry_t no_cdb = '0;

    logic clock = 1'b0;
    logic reset;
    logic squash;
    dispatch_slot_t dispatch_0, dispatch_1;
    cdb_entry_t     cdb_0, cdb_1;
    rs_mt_packet_t  lookup_0, lookup_1;
    logic           dispatch_ready;
    mt_rs_packet_t  operands_0, operands_1;
    retire_packet_t retire_0, retire_1;

    // reference model state
    rob_tag_t            ref_tag [reg_size];
    logic [reg_size-1:0] ref_ready;
    logic [rob_size-1:0] ref_valid, ref_complete, ref_has_dest;
    arch_reg_t           ref_dest [rob_size];
    rob_idx_t            ref_head, ref_tail;
    int                  ref_count;
    logic                exp_ret0, exp_ret1;
    logic [31:0]         lfsr_state = 32'h5ae3;
    string               test_name;

    rename_core rename_core_inst (.*);

    always #4 clock = ~clock;

    initial begin
        #(cycle_budget * 8 + 400);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'ha300_0000 : 32'h0);
            val = {val[30:0], b};
        end
        return val;
    endfunction

    function automatic dispatch_slot_t rand_dest();
        arch_reg_t r;
        r = arch_reg_t'(lfsr_bits(3));
        // small register range so renames collide often
        if (r == '0) r = arch_reg_t'(1);
        return '{valid: 1'b1, has_dest: 1'b1, dest_reg: r};
    endfunction

    function automatic rs_mt_packet_t rand_lookup();
        rs_mt_packet_t p;
        p.register_idxes[0] = arch_reg_t'(lfsr_bits(5));
        p.register_idxes[1] = arch_reg_t'(lfsr_bits(5));
        return p;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_operand(input operand_info_t exp, input operand_info_t act);
        if (exp !== act)
            fail_run($sformatf("FAIL %s operand expected %h actual %h", test_name, exp, act));
    endtask

    task automatic check_retire(input retire_packet_t exp, input retire_packet_t act);
        // fields only matter on a valid retire
        if (exp.valid ? (exp !== act) : (act.valid !== 1'b0))
            fail_run($sformatf("FAIL %s retire expected %h actual %h", test_name, exp, act));
    endtask

    task automatic check_ready(input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("FAIL %s ready expected %b actual %b", test_name, exp, act));
    endtask

    function automatic operand_info_t exp_operand(input arch_reg_t r, input logic fwd,
                                                  input dispatch_slot_t d0, input logic f0);
        operand_info_t info;
        rob_idx_t      h1;
        h1 = ref_head + rob_idx_t'(1);
        info.tag   = ref_tag[r];
        info.ready = ref_ready[r];
        if ((exp_ret0 && ref_has_dest[ref_head] && ref_dest[ref_head] == r &&
             ref_tag[r] == {1'b0, ref_head}) ||
            (exp_ret1 && ref_has_dest[h1] && ref_dest[h1] == r && ref_tag[r] == {1'b0, h1})) begin
            info = '{tag: zero_tag, ready: 1'b0};
        end
        if (fwd && f0 && d0.has_dest && d0.dest_reg == r)
            info = '{tag: {1'b0, ref_tail}, ready: 1'b0};
        return info;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < reg_size; i++) ref_tag[i] = zero_tag;
        ref_ready = '0;
        ref_valid = '0;
        ref_complete = '0;
        ref_head = '0;
        ref_tail = '0;
        ref_count = 0;
    endtask

    // drive one cycle, check at the falling edge and advance the model
    task automatic step(input dispatch_slot_t d0, input dispatch_slot_t d1,
                        input cdb_entry_t c0, input cdb_entry_t c1,
                        input rs_mt_packet_t l0, input rs_mt_packet_t l1, input logic sq);
        logic     rdy, f0, f1;
        rob_idx_t h1, t1;
        rob_tag_t old_tag [reg_size];
        @(posedge clock);
        dispatch_0 <= d0;
        dispatch_1 <= d1;
        cdb_0 <= c0;
        cdb_1 <= c1;
        lookup_0 <= l0;
        lookup_1 <= l1;
        squash <= sq;
        @(negedge clock);
        h1 = ref_head + rob_idx_t'(1);
        rdy = ref_count <= rob_size - 2;
        f0 = d0.valid && rdy;
        f1 = d1.valid && rdy;
        exp_ret0 = ref_valid[ref_head] && ref_complete[ref_head];
        exp_ret1 = exp_ret0 && ref_valid[h1] && ref_complete[h1];
        check_ready(rdy, dispatch_ready);
        check_retire('{valid: exp_ret0, has_dest: ref_has_dest[ref_head],
                       dest_reg: ref_dest[ref_head], tag: {1'b0, ref_head}}, retire_0);
        check_retire('{valid: exp_ret1, has_dest: ref_has_dest[h1],
                       dest_reg: ref_dest[h1], tag: {1'b0, h1}}, retire_1);
        for (int s = 0; s < 2; s++) begin
            check_operand(exp_operand(l0.register_idxes[s], 1'b0, d0, f0), operands_0.rs_infos[s]);
            check_operand(exp_operand(l1.register_idxes[s], 1'b1, d0, f0), operands_1.rs_infos[s]);
        end
        if (sq) begin
            model_clear();
        end else begin
            old_tag = ref_tag;
            // retire, then completion, then dispatch
            if (exp_ret0 && ref_has_dest[ref_head] &&
                old_tag[ref_dest[ref_head]] == {1'b0, ref_head})
                ref_tag[ref_dest[ref_head]] = zero_tag;
            if (exp_ret1 && ref_has_dest[h1] && old_tag[ref_dest[h1]] == {1'b0, h1})
                ref_tag[ref_dest[h1]] = zero_tag;
            for (int i = 0; i < reg_size; i++) begin
                if (ref_tag[i] == zero_tag && old_tag[i] != zero_tag) ref_ready[i] = 1'b0;
                if ((c0.valid && old_tag[i] == c0.tag) || (c1.valid && old_tag[i] == c1.tag))
                    ref_ready[i] = 1'b1;
            end
            if (exp_ret0) ref_valid[ref_head] = 1'b0;
            if (exp_ret1) ref_valid[h1] = 1'b0;
            ref_head = ref_head + rob_idx_t'(exp_ret0) + rob_idx_t'(exp_ret1);
            ref_count = ref_count - int'(exp_ret0) - int'(exp_ret1);
            if (c0.valid) ref_complete[rob_idx_t'(c0.tag)] = 1'b1;
            if (c1.valid) ref_complete[rob_idx_t'(c1.tag)] = 1'b1;
            t1 = ref_tail + rob_idx_t'(f0);
            for (int k = 0; k < 2; k++) begin
                if (k == 0 ? f0 : f1) begin
                    rob_idx_t       t;
                    dispatch_slot_t d;
                    t = (k == 0) ? ref_tail : t1;
                    d = (k == 0) ? d0 : d1;
                    ref_valid[t] = 1'b1;
                    ref_complete[t] = 1'b0;
                    ref_has_dest[t] = d.has_dest;
                    ref_dest[t] = d.dest_reg;
                    if (d.has_dest) begin
                        ref_tag[d.dest_reg] = {1'b0, t};
                        ref_ready[d.dest_reg] = 1'b0;
                    end
                end
            end
            ref_tail = ref_tail + rob_idx_t'(f0) + rob_idx_t'(f1);
            ref_count = ref_count + int'(f0) + int'(f1);
        end
    endtask

    // completes in-flight entries in lfsr order until the buffer is empty
    task automatic drain();
        int            guard;
        rob_idx_t      idx;
        cdb_entry_t    c0;
        rs_mt_packet_t l0;
        guard = 0;
        while (ref_count > 0) begin
            c0 = no_cdb;
            idx = ref_head + rob_idx_t'(lfsr_bits(5) % ref_count);
            for (int n = 0; n < rob_size; n++) begin
                if (!c0.valid && ref_valid[idx] && !ref_complete[idx])
                    c0 = '{valid: 1'b1, tag: {1'b0, idx}};
                idx = idx + rob_idx_t'(1);
            end
            l0 = rand_lookup();
            // watch the head register so the retiring cycle is seen
            l0.register_idxes[0] = ref_dest[ref_head];
            step(no_disp, no_disp, c0, no_cdb, l0, rand_lookup(), 1'b0);
            guard++;
            if (guard > 200) fail_run("the reorder buffer did not drain");
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_reset();
        test_name = "reset";
        repeat (4) step(no_disp, no_disp, no_cdb, no_cdb, rand_lookup(), rand_lookup(), 1'b0);
    endtask

    task automatic test_dispatch_retire();
        dispatch_slot_t d0, d1;
        rs_mt_packet_t  l1;
        test_name = "dispatch";
        repeat (12) begin
            d0 = rand_dest();
            d1 = rand_dest();
            d1.has_dest = 1'(lfsr_bits(1));
            l1 = rand_lookup();
            l1.register_idxes[0] = d0.dest_reg;
            step(d0, d1, no_cdb, no_cdb, rand_lookup(), l1, 1'b0);
        end
        test_name = "complete_retire";
        drain();
    endtask

    task automatic test_backpressure();
        dispatch_slot_t d0, d1;
        rs_mt_packet_t  l1;
        test_name = "backpressure";
        while (ref_count < rob_size - 1) begin
            step(rand_dest(), (ref_count <= rob_size - 3) ? rand_dest() : no_disp,
                 no_cdb, no_cdb, rand_lookup(), rand_lookup(), 1'b0);
        end
        // hold an offered bundle and watch its destinations
        d0 = rand_dest();
        d1 = rand_dest();
        l1.register_idxes[0] = d0.dest_reg;
        l1.register_idxes[1] = d1.dest_reg;
        repeat (3) step(d0, d1, no_cdb, no_cdb, l1, l1, 1'b0);
        step(no_disp, no_disp, '{valid: 1'b1, tag: {1'b0, ref_head}}, no_cdb,
             rand_lookup(), rand_lookup(), 1'b0);
        repeat (2) step(no_disp, no_disp, no_cdb, no_cdb, rand_lookup(), rand_lookup(), 1'b0);
        check_ready(1'b1, dispatch_ready);
        drain();
    endtask

    task automatic test_squash();
        rs_mt_packet_t l1;
        test_name = "squash";
        repeat (3) step(rand_dest(), rand_dest(), no_cdb, no_cdb,
                        rand_lookup(), rand_lookup(), 1'b0);
        step(no_disp, no_disp, '{valid: 1'b1, tag: {1'b0, ref_head}}, no_cdb,
             rand_lookup(), rand_lookup(), 1'b0);
        step(no_disp, no_disp, no_cdb, no_cdb, rand_lookup(), rand_lookup(), 1'b1);
        repeat (2) step(no_disp, no_disp, no_cdb, no_cdb, rand_lookup(), rand_lookup(), 1'b0);
        l1 = rand_lookup();
        l1.register_idxes[1] = arch_reg_t'(3);
        step('{valid: 1'b1, has_dest: 1'b1, dest_reg: arch_reg_t'(3)}, no_disp,
             no_cdb, no_cdb, rand_lookup(), l1, 1'b0);
        drain();
    endtask

    initial begin
        reset = 1'b1;
        squash = 1'b0;
        dispatch_0 = '0;
        dispatch_1 = '0;
        cdb_0 = '0;
        cdb_1 = '0;
        lookup_0 = '0;
        lookup_1 = '0;
        ref_has_dest = '0;
        for (int i = 0; i < rob_size; i++) ref_dest[i] = '0;
        model_clear();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        test_reset();
        test_dispatch_retire();
        test_backpressure();
        test_squash();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verilog.f */
hdl/rename_pkg.sv
hdl/map_table.sv
hdl/reorder_buffer.sv
hdl/rename_core.sv
verification/rename_core_props.sv
verification/rename_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_core_tb -f verilog.f -o rename_core_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/rename_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1
